// File: Makefile
# Verilator build and run for the cheat loader testbench

TOP := cheat_loader_tb

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): cheat_loader.f cheat_loader_params.svh $(wildcard *.sv)
	verilator --binary --timing -f cheat_loader.f --top-module $(TOP) -Mdir obj_dir

# pass only if the testbench printed the pass line
run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation passed"

lint:
	verilator --lint-only --timing -f cheat_loader.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// File: cheat_descrambler.sv
//**************************************************
// cheat descrambler
// recovers plain firmware bytes using address keyed
// bit pair swaps around a fixed XOR
//**************************************************

`timescale 1ns/1ps
`default_nettype none

`include "cheat_loader_params.svh"

module cheat_descrambler import cheat_loader_pkg::*; (
    input  wire prog_byte_t byte_in,   // scrambled beat
    output prog_byte_t      byte_out   // same beat, plain data
);

    logic [7:0] mask;       // per byte swap selection
    logic [7:0] swap_lo;    // after first swap pass
    logic [7:0] xored;      // after key XOR
    logic [7:0] plain;      // after second swap pass

    // swap bits 2i+1:2i when sel[i] is set
    function automatic logic [7:0] swap_pairs(
        input logic [7:0] d,
        input logic [3:0] sel
    );
        logic [7:0] r;
        r = d;
        for (int i = 0; i < 4; i++) begin
            if (sel[i]) begin
                r[2*i +: 2] = {d[2*i], d[2*i+1]};  // exchange the pair
            end
        end
        return r;
    endfunction

    // mask depends on where the byte sits in the stream
    assign mask = byte_in.addr ^ `CHEAT_KEY_LO;

    // pass 1 under mask low nibble
    assign swap_lo = swap_pairs(byte_in.data, mask[3:0]);

    // fixed pattern flip between passes
    assign xored = swap_lo ^ `CHEAT_KEY_HI;

    // pass 2 under mask high nibble
    assign plain = swap_pairs(xored, mask[7:4]);

    // strobe and address untouched
    assign byte_out = '{
        wr:   byte_in.wr,
        addr: byte_in.addr,
        data: plain
    };

endmodule

`default_nettype wire

// File: cheat_loader.f
+incdir+.
cheat_loader_pkg.sv
cheat_descrambler.sv
cheat_word_packer.sv
cheat_prog_ram.sv
cheat_loader.sv
cheat_loader_tb.sv

// File: cheat_loader.sv
//**************************************************
// cheat loader top
// descrambles host bytes, packs them into the program
// RAM and serves instruction fetch once loaded
//**************************************************

`timescale 1ns/1ps
`default_nettype none

`include "cheat_loader_params.svh"

module cheat_loader import cheat_loader_pkg::*; (
    input  wire                 clk,
    input  wire                 rst,
    // host download side
    input  wire                 prog_en,     // level, edge restarts load
    input  wire                 prog_wr,     // byte strobe
    input  wire [7:0]           prog_addr,   // stream address
    input  wire [7:0]           prog_data,   // scrambled byte
    // controller fetch side
    input  wire [`CHEAT_AW-1:0] iaddr,
    output instr_t              idata
);

    prog_byte_t byte_raw;    // host beat as received
    prog_byte_t byte_plain;  // after descramble
    prog_word_t word_wr;     // packed RAM write
    instr_t     ram_q;       // raw fetch data
    logic       loaded;      // at least one word written

    assign byte_raw = '{
        wr:   prog_wr,
        addr: prog_addr,
        data: prog_data
    };

    cheat_descrambler u_descr (
        .byte_in  (byte_raw),
        .byte_out (byte_plain)
    );

    cheat_word_packer u_packer (
        .clk      (clk),
        .rst      (rst),
        .prog_en  (prog_en),
        .byte_in  (byte_plain),
        .word_out (word_wr)
    );

    cheat_prog_ram u_ram (
        .clk   (clk),
        .wr    (word_wr),
        .raddr (iaddr),
        .rdata (ram_q)
    );

    // sticky until reset, a reload does not clear it
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            loaded <= 1'b0;
        end else if (word_wr.we) begin
            loaded <= 1'b1;   // first write
        end
    end

    // blank fetch keeps the controller on zeros until firmware lands
    assign idata = loaded ? ram_q : '0;

endmodule

`default_nettype wire

// File: cheat_loader_params.svh
//**************************************************
// cheat loader parameters
// program RAM geometry and the firmware scramble key
//**************************************************

`ifndef CHEAT_LOADER_PARAMS_SVH
`define CHEAT_LOADER_PARAMS_SVH

// program RAM address width, 1024 words by default
`define CHEAT_AW 10

// instruction word width of the cheat controller
`define CHEAT_DW 18

// scramble key, split in two halves
// low half is XORed with the stream address to form the swap mask
`define CHEAT_KEY_LO 8'h5a

// high half is the XOR pattern applied between the two swap passes
`define CHEAT_KEY_HI 8'hc3

// nine bytes pack into four words
// 9*8 = 72 = 4*18, so no bits are lost at group end
// changing CHEAT_DW breaks that ratio, packer assumes 18

`endif

// File: cheat_loader_pkg.sv
//**************************************************
// cheat loader types
// loader byte beat, RAM write beat, instruction word
//**************************************************

`default_nettype none

`include "cheat_loader_params.svh"

package cheat_loader_pkg;

    // one instruction as seen on the fetch port
    typedef logic [`CHEAT_DW-1:0] instr_t;

    // one byte from the host download stream
    typedef struct packed {
        logic       wr;    // one cycle strobe
        logic [7:0] addr;  // stream address, keys the descramble
        logic [7:0] data;  // byte payload
    } prog_byte_t;         // 17 bits

    // one packed write into the program RAM
    typedef struct packed {
        logic                 we;    // write enable, single cycle
        logic [`CHEAT_AW-1:0] addr;  // word address
        instr_t               data;  // packed instruction
    } prog_word_t;                   // 29 bits at AW=10

endpackage

`default_nettype wire

// File: cheat_loader_tb.sv
//**************************************************
// cheat loader testbench
// streams scrambled firmware through the loader and
// checks fetched words against a descramble/pack model
//**************************************************

`timescale 1ns/1ps
`default_nettype none

`include "cheat_loader_params.svh"

module cheat_loader_tb import cheat_loader_pkg::*; ();

    typedef logic [`CHEAT_AW-1:0] waddr_t;

    typedef enum logic {ACT_LOAD, ACT_FETCH} act_e;

    // one row of the stimulus table
    typedef struct packed {
        act_e       act;        // load bytes or fetch words
        logic [7:0] count;      // bytes to load, or words to fetch from 0
        logic       toggle;     // drop and raise prog_en first
        logic       rst_first;  // pulse rst before the fetch
        logic       gaps;       // random idle cycles between bytes
        logic [1:0] stream;     // which byte stream to load
    } test_row_t;

    localparam int ROWS = 9;

    logic           clk;
    logic           rst;
    logic           prog_en;
    logic           prog_wr;
    logic [7:0]     prog_addr;
    logic [7:0]     prog_data;
    waddr_t         iaddr;
    instr_t         idata;

    test_row_t      rows [ROWS] = '{
        '{ACT_LOAD,  8'd36, 1'b1, 1'b0, 1'b0, 2'd0},   // four groups back to back
        '{ACT_FETCH, 8'd20, 1'b0, 1'b0, 1'b0, 2'd0},
        '{ACT_LOAD,  8'd36, 1'b1, 1'b0, 1'b1, 2'd0},   // same stream with idle gaps
        '{ACT_FETCH, 8'd20, 1'b0, 1'b0, 1'b0, 2'd0},
        '{ACT_LOAD,  8'd18, 1'b1, 1'b0, 1'b0, 2'd1},   // shorter new stream
        '{ACT_FETCH, 8'd20, 1'b0, 1'b0, 1'b0, 2'd0},
        '{ACT_LOAD,  8'd13, 1'b1, 1'b0, 1'b0, 2'd2},   // one group plus four bytes
        '{ACT_FETCH, 8'd20, 1'b0, 1'b0, 1'b0, 2'd0},
        '{ACT_FETCH, 8'd16, 1'b0, 1'b1, 1'b0, 2'd0}    // RAM still full, gate closed
    };
    string          row_name [ROWS] = '{"full_load", "full_fetch", "gap_load", "gap_fetch",
        "reload", "reload_fetch", "partial_load", "partial_fetch", "blank_fetch"};
    logic [7:0]     streams [0:2][0:35];   // scrambled bytes as the host sends them
    instr_t         exp_mem [0:63];        // expected RAM contents
    logic           exp_loaded;            // model of the loaded gate
    int             errors;
    int             row_errors;
    int             cycle_cnt;
    int             cycle_limit;

    cheat_loader UUT (
        .clk       (clk),
        .rst       (rst),
        .prog_en   (prog_en),
        .prog_wr   (prog_wr),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .iaddr     (iaddr),
        .idata     (idata)
    );

    always #20 clk = ~clk;   // 40 ns period

    // run guard
    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("Simulation failed");
            $finish;
        end
    end

    task automatic check_word(input string what, input instr_t exp, input instr_t got);
        if (got !== exp) begin
            $display("mismatch %s: expected %h, actual %h", what, exp, got);
            errors++;
            row_errors++;
        end
    endtask

    task automatic check_count(input string what, input waddr_t exp, input waddr_t got);
        if (got !== exp) begin
            $display("mismatch %s: expected %0d, actual %0d", what, exp, got);
            errors++;
            row_errors++;
        end
    endtask

    // two swap passes around the key XOR, pair p keyed by mask bit p / p+4
    function automatic logic [7:0] unscramble(input logic [7:0] a, input logic [7:0] d);
        logic [7:0] m;
        logic [7:0] b;
        logic       t;
        m = a ^ `CHEAT_KEY_LO;
        b = d;
        for (int pass = 0; pass < 2; pass++) begin
            for (int p = 0; p < 4; p++) begin
                if (m[4*pass + p]) begin
                    t        = b[2*p];
                    b[2*p]   = b[2*p+1];
                    b[2*p+1] = t;
                end
            end
            if (pass == 0) begin
                b = b ^ `CHEAT_KEY_HI;   // between the passes only
            end
        end
        return b;
    endfunction

    // expected words for one load, writes start over at word 0
    task automatic model_load(input int s, input int n);
        logic [71:0] grp;
        int          pos;
        int          waddr;
        grp   = '0;
        waddr = 0;
        for (int i = 0; i < n; i++) begin
            pos = i % 9;
            if (pos == 0) begin
                grp = '0;   // new group of nine
            end
            grp[8*pos +: 8] = unscramble(8'(i), streams[s][i]);
            if (pos == 2 || pos == 4 || pos == 6 || pos == 8) begin
                exp_mem[waddr] = grp[18*(pos/2 - 1) +: 18];
                waddr++;
                exp_loaded = 1'b1;
            end
        end
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        #2 prog_wr = 1'b0;
    endtask

    task automatic send_byte(input logic [7:0] a, input logic [7:0] d);
        @(posedge clk);
        #2;
        prog_wr   = 1'b1;
        prog_addr = a;
        prog_data = d;
    endtask

    // host side of one download
    task automatic run_load(input int s, input int n, input logic toggle, input logic gaps);
        int gap;
        if (toggle) begin
            idle_cycle();
            prog_en = 1'b0;
            for (int k = 0; k < 9; k++) begin
                send_byte(8'(k), 8'($urandom));   // stray, enable is low
            end
            idle_cycle();
            // enable edge with a junk byte, dropped by the packer
            send_byte(8'h00, 8'($urandom));
            prog_en = 1'b1;
        end
        for (int i = 0; i < n; i++) begin
            if (gaps) begin
                gap = $urandom % 3;
                repeat (gap) idle_cycle();
            end
            send_byte(8'(i), streams[s][i]);
        end
        repeat (3) idle_cycle();   // let the last write land
    endtask

    // pipelined fetch, one new address per cycle
    task automatic run_fetch(input string name, input int n);
        waddr_t exp_nz;
        waddr_t got_nz;
        instr_t exp_w;
        exp_nz = '0;
        got_nz = '0;
        for (int i = 0; i <= n; i++) begin
            @(posedge clk);
            #2 iaddr = (i < n) ? waddr_t'(i) : '0;
            #1;   // data for the previous address, after the new one is up
            if (i > 0) begin
                exp_w = exp_loaded ? exp_mem[i-1] : '0;
                check_word($sformatf("%s[%0d]", name, i - 1), exp_w, idata);
                exp_nz += waddr_t'(exp_w != '0);
                got_nz += waddr_t'(idata != '0);
            end
        end
        check_count($sformatf("%s nonzero words", name), exp_nz, got_nz);
    endtask

    initial begin
        int len_sum;
        int passed;
        clk       = 1'b0;
        rst       = 1'b1;
        prog_en   = 1'b0;
        prog_wr   = 1'b0;
        prog_addr = 8'h00;
        prog_data = 8'h00;
        iaddr     = '0;
        errors    = 0;
        passed    = 0;
        cycle_cnt = 0;
        exp_loaded = 1'b0;
        void'($urandom(32'h1276abc9));   // single seed for the run
        for (int w = 0; w < 64; w++) begin
            exp_mem[w] = '0;
        end
        for (int s = 0; s < 3; s++) begin
            for (int i = 0; i < 36; i++) begin
                streams[s][i] = 8'($urandom);
            end
        end
        len_sum = 0;
        for (int r = 0; r < ROWS; r++) begin
            len_sum += int'(rows[r].count);
        end
        cycle_limit = 2 * len_sum + 100;

        repeat (3) @(posedge clk);
        #2 rst = 1'b0;

        for (int r = 0; r < ROWS; r++) begin
            row_errors = 0;
            if (rows[r].act == ACT_LOAD) begin
                run_load(int'(rows[r].stream), int'(rows[r].count), rows[r].toggle,
                         rows[r].gaps);
                model_load(int'(rows[r].stream), int'(rows[r].count));
            end else begin
                if (rows[r].rst_first) begin
                    idle_cycle();
                    rst        = 1'b1;   // loaded flag drops, RAM keeps its words
                    exp_loaded = 1'b0;
                    repeat (3) idle_cycle();
                    rst = 1'b0;
                end
                run_fetch(row_name[r], int'(rows[r].count));
            end
            if (row_errors == 0) begin
                passed++;
                $display("test %s: ok", row_name[r]);
            end else begin
                $display("test %s: %0d errors", row_name[r], row_errors);
            end
        end

        $display("tests %0d, passed %0d, failed %0d, errors %0d",
                 ROWS, passed, ROWS - passed, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: cheat_prog_ram.sv
//**************************************************
// cheat program RAM
// dual port store, load writes on A, fetch on B
//**************************************************

`timescale 1ns/1ps
`default_nettype none

`include "cheat_loader_params.svh"

module cheat_prog_ram import cheat_loader_pkg::*; (
    input  wire                 clk,
    input  wire prog_word_t     wr,      // port A write beat
    input  wire [`CHEAT_AW-1:0] raddr,   // port B fetch address
    output instr_t              rdata    // port B data, one cycle later
);

    localparam int DEPTH = 1 << `CHEAT_AW;

    instr_t mem [0:DEPTH-1];   // program words

    // start from a blank store, no firmware image
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    // port A, load side
    always_ff @(posedge clk) begin
        if (wr.we) begin
            mem[wr.addr] <= wr.data;
        end
    end

    // port B, registered read
    // same address collision returns the old word
    always_ff @(posedge clk) begin
        rdata <= mem[raddr];
    end

endmodule

`default_nettype wire

// File: cheat_word_packer.sv
//**************************************************
// cheat word packer
// packs 8 bit bytes into 18 bit words, 9 bytes to 4,
// and steps the program RAM write address
//**************************************************

`timescale 1ns/1ps
`default_nettype none

`include "cheat_loader_params.svh"

module cheat_word_packer import cheat_loader_pkg::*; (
    input  wire             clk,
    input  wire             rst,
    input  wire             prog_en,   // level, rising edge restarts
    input  wire prog_byte_t byte_in,   // plain byte beat
    output prog_word_t      word_out   // RAM write port
);

    localparam int AW = `CHEAT_AW;

    logic          en_q;       // last prog_en
    logic [3:0]    byte_cnt;   // position in group, 0..8
    logic [15:0]   carry;      // leftover bits, newest byte on top
    logic          wr_en;      // registered write strobe
    logic [AW-1:0] wr_addr;    // next word address
    instr_t        wr_data;    // registered word

    logic          restart;    // enable rising edge
    logic          take;       // byte accepted this cycle
    logic          word_hit;   // this byte completes a word
    instr_t        word_next;  // word formed from carry and byte

    assign restart = prog_en & ~en_q;
    assign take    = byte_in.wr & prog_en & ~restart;  // edge cycle drops the byte

    // word boundaries fall on the 3rd, 5th, 7th and 9th byte
    always_comb begin
        word_hit  = 1'b0;
        word_next = '0;
        case (byte_cnt)
            4'd2: begin
                word_hit  = 1'b1;
                word_next = {byte_in.data[1:0], carry};         // bits 17:0
            end
            4'd4: begin
                word_hit  = 1'b1;
                word_next = {byte_in.data[3:0], carry[15:2]};   // bits 35:18
            end
            4'd6: begin
                word_hit  = 1'b1;
                word_next = {byte_in.data[5:0], carry[15:4]};   // bits 53:36
            end
            4'd8: begin
                word_hit  = 1'b1;
                word_next = {byte_in.data, carry[15:6]};        // bits 71:54
            end
            default: begin
                word_hit  = 1'b0;                               // byte just carried
            end
        endcase
    end

    // control state
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            en_q     <= 1'b0;
            byte_cnt <= 4'd0;
            wr_en    <= 1'b0;
            wr_addr  <= '0;
        end else begin
            en_q <= prog_en;
            if (restart) begin
                byte_cnt <= 4'd0;   // new group
                wr_en    <= 1'b0;
                wr_addr  <= '0;     // reload from word 0
            end else begin
                if (wr_en) begin
                    wr_addr <= wr_addr + AW'(1);  // step after each write
                end
                wr_en <= take & word_hit;
                if (take) begin
                    byte_cnt <= (byte_cnt == 4'd8) ? 4'd0 : byte_cnt + 4'd1;
                end
            end
        end
    end

    // payload, shifts right one byte per accepted beat
    always_ff @(posedge clk) begin
        if (restart) begin
            carry   <= '0;
            wr_data <= '0;
        end else if (take) begin
            carry <= {byte_in.data, carry[15:8]};
            if (word_hit) begin
                wr_data <= word_next;
            end
        end
    end

    assign word_out = '{
        we:   wr_en,
        addr: wr_addr,
        data: wr_data
    };

endmodule

`default_nettype wire
